// ==== build.f ====
+incdir+hdl
+incdir+dv
hdl/cart_pkg.sv
hdl/slot_timer.sv
hdl/mem_cycle_fsm.sv
hdl/rom_addr_mux.sv
hdl/rom_data_path.sv
hdl/cart_main.sv
dv/tb_cart_main.sv

// ==== dv/tb_stim_table.svh ====
`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

// Columns: operation, byte address, ROM mask, write data, expected byte
// Expected byte of -1 takes the value from the reference image
localparam int NUM_ROWS = 17;

int stim_rows [NUM_ROWS][5] = '{
   '{OP_SNES_RD, 'h000020, 'hFFFFFF, 'h00, -1},
   '{OP_SNES_RD, 'h000021, 'hFFFFFF, 'h00, -1},
   '{OP_SNES_WR, 'h000030, 'hFFFFFF, 'h5A, -1},
   '{OP_SNES_RD, 'h000030, 'hFFFFFF, 'h00, 'h5A},
   '{OP_SNES_RD, 'h000031, 'hFFFFFF, 'h00, -1},
   '{OP_SNES_WR, 'h000045, 'hFFFFFF, 'hC3, -1},
   '{OP_SNES_RD, 'h000045, 'hFFFFFF, 'h00, 'hC3},
   // Narrow mask, 0x110 wraps onto 0x010
   '{OP_SNES_WR, 'h000010, 'h0000FF, 'hA5, -1},
   '{OP_SNES_RD, 'h000110, 'h0000FF, 'h00, 'hA5},
   '{OP_SNES_RD, 'h000110, 'hFFFFFF, 'h00, -1},
   '{OP_MCU_WR,  'h000062, 'hFFFFFF, 'h3C, -1},
   '{OP_SNES_RD, 'h000062, 'hFFFFFF, 'h00, 'h3C},
   '{OP_MCU_WR,  'h000063, 'hFFFFFF, 'h96, -1},
   '{OP_SNES_RD, 'h000062, 'hFFFFFF, 'h00, 'h3C},
   '{OP_MCU_RD,  'h000063, 'hFFFFFF, 'h00, 'h96},
   // MCU address bypasses the mask
   '{OP_MCU_RD,  'h000151, 'h0000FF, 'h00, -1},
   '{OP_MCU_RD,  'h000010, 'h0000FF, 'h00, 'hA5}
};

`endif

// ==== dv/tb_cart_main.sv ====
module tb_cart_main;
   import cart_pkg::*;

   localparam int PERIOD       = 10;
   localparam int RESET_CYCLES = 5;
   localparam int MODEL_DEPTH  = 256;
   localparam int SEED         = 32'h838b;
   localparam int LOW_CYCLES   = 8;
   localparam int HIGH_CYCLES  = 22;
   localparam int WAIT_LIMIT   = 40;

   // Table operations and columns
   localparam int OP_SNES_RD = 0;
   localparam int OP_SNES_WR = 1;
   localparam int OP_MCU_RD  = 2;
   localparam int OP_MCU_WR  = 3;
   localparam int COL_OP     = 0;
   localparam int COL_ADDR   = 1;
   localparam int COL_MASK   = 2;
   localparam int COL_DATA   = 3;
   localparam int COL_EXP    = 4;

   `include "tb_stim_table.svh"

   logic       CLK2;
   logic       rst_n;
   logic       snes_cpu_clk;
   snes_addr_t snes_addr;
   logic       snes_read_n;
   logic       snes_write_n;
   byte_t      snes_wdata;
   snes_addr_t rom_mask;
   word_t      rom_rdata;
   logic       mcu_req_valid;
   logic       mcu_req_write;
   snes_addr_t mcu_addr;
   byte_t      mcu_wdata;
   byte_t      snes_rdata;
   logic       snes_data_oe;
   rom_addr_t  rom_addr;
   word_t      rom_wdata;
   logic       rom_we_n;
   logic       rom_oe_n;
   logic       rom_bhe_n;
   logic       rom_ble_n;
   logic       mcu_req_ready;
   byte_t      mcu_rdata;
   logic       mcu_rdata_valid;

   word_t rom_mem [MODEL_DEPTH];
   word_t ref_mem [MODEL_DEPTH];
   int    rvalid_count = 0;
   byte_t rvalid_byte  = 8'h00;

   cart_main UUT (
      .CLK2            (CLK2),
      .rst_n           (rst_n),
      .snes_cpu_clk    (snes_cpu_clk),
      .snes_addr       (snes_addr),
      .snes_read_n     (snes_read_n),
      .snes_write_n    (snes_write_n),
      .snes_wdata      (snes_wdata),
      .rom_mask        (rom_mask),
      .rom_rdata       (rom_rdata),
      .mcu_req_valid   (mcu_req_valid),
      .mcu_req_write   (mcu_req_write),
      .mcu_addr        (mcu_addr),
      .mcu_wdata       (mcu_wdata),
      .snes_rdata      (snes_rdata),
      .snes_data_oe    (snes_data_oe),
      .rom_addr        (rom_addr),
      .rom_wdata       (rom_wdata),
      .rom_we_n        (rom_we_n),
      .rom_oe_n        (rom_oe_n),
      .rom_bhe_n       (rom_bhe_n),
      .rom_ble_n       (rom_ble_n),
      .mcu_req_ready   (mcu_req_ready),
      .mcu_rdata       (mcu_rdata),
      .mcu_rdata_valid (mcu_rdata_valid)
   );

   initial begin
      CLK2 = 1'b0;
      forever #(PERIOD / 2) CLK2 = ~CLK2;
   end

   //////////////////////////////////////////////////////////////////////
   // ROM model and MCU read monitor
   //////////////////////////////////////////////////////////////////////

   assign rom_rdata = rom_oe_n ? '0 : rom_mem[rom_addr[7:0]];

   // Lanes stored when WE rises
   always @(posedge rom_we_n) begin
      if (rst_n) begin
         if (!rom_bhe_n) begin
            rom_mem[rom_addr[7:0]][15:8] = rom_wdata[15:8];
         end
         if (!rom_ble_n) begin
            rom_mem[rom_addr[7:0]][7:0] = rom_wdata[7:0];
         end
      end
   end

   always @(negedge CLK2) begin
      if (mcu_rdata_valid) begin
         rvalid_count = rvalid_count + 1;
         rvalid_byte  = mcu_rdata;
      end
   end

   initial begin
      #((NUM_ROWS * 40 + RESET_CYCLES + 2) * PERIOD);
      $display("Watchdog expired, the run took longer than the tests allow");
      $display("Test failed");
      $fatal(1, "watchdog");
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("Fail at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "mismatch");
      end
   endtask

   function automatic byte_t expected_byte(input snes_addr_t byte_addr);
      word_t w;
      w = ref_mem[byte_addr[8:1]];
      return byte_addr[0] ? w[15:8] : w[7:0];
   endfunction

   task automatic update_reference(input snes_addr_t byte_addr, input byte_t data);
      if (byte_addr[0]) begin
         ref_mem[byte_addr[8:1]][15:8] = data;
      end else begin
         ref_mem[byte_addr[8:1]][7:0] = data;
      end
   endtask

   // Slow console clock, long enough high for the full schedule
   task automatic run_console_cycle(input logic rd, input logic wr,
                                    input snes_addr_t addr, input byte_t data);
      snes_addr    = addr;
      snes_wdata   = data;
      snes_read_n  = !rd;
      snes_write_n = !wr;
      snes_cpu_clk = 1'b0;
      repeat (LOW_CYCLES) @(posedge CLK2);
      check_value(32'(snes_data_oe), 32'(rd), "console data output enable");
      #1 snes_cpu_clk = 1'b1;
      repeat (HIGH_CYCLES) @(posedge CLK2);
      #1 snes_read_n = 1'b1;
      snes_write_n = 1'b1;
   endtask

   task automatic wait_grant();
      int waited;
      waited = 0;
      @(negedge CLK2);
      while (!mcu_req_ready) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            $display("MCU request was not accepted within %0d cycles", WAIT_LIMIT);
            $display("Test failed");
            $fatal(1, "grant timeout");
         end
         @(negedge CLK2);
      end
      @(posedge CLK2);
      #1 mcu_req_valid = 1'b0;
   endtask

   task automatic wait_rdata(input int count_before);
      int waited;
      waited = 0;
      while (rvalid_count == count_before) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            $display("No MCU read data came back within %0d cycles", WAIT_LIMIT);
            $display("Test failed");
            $fatal(1, "read data timeout");
         end
         @(negedge CLK2);
      end
      @(posedge CLK2);
      #1;
   endtask

   // Console stays idle while the MCU request rides the schedule
   task automatic request_mcu(input logic wr, input snes_addr_t addr, input byte_t data);
      mcu_req_valid = 1'b1;
      mcu_req_write = wr;
      mcu_addr      = addr;
      mcu_wdata     = data;
      fork
         run_console_cycle(1'b0, 1'b0, '0, 8'h00);
         wait_grant();
      join
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int         op;
      int         count_before;
      snes_addr_t addr;
      snes_addr_t eff;
      byte_t      data;
      byte_t      exp_b;

      void'($urandom(SEED));
      for (int i = 0; i < MODEL_DEPTH; i++) begin
         rom_mem[i] = word_t'($urandom);
         ref_mem[i] = rom_mem[i];
      end
      rst_n         = 1'b0;
      snes_cpu_clk  = 1'b1;
      snes_addr     = '0;
      snes_read_n   = 1'b1;
      snes_write_n  = 1'b1;
      snes_wdata    = 8'h00;
      rom_mask      = '1;
      mcu_req_valid = 1'b0;
      mcu_req_write = 1'b0;
      mcu_addr      = '0;
      mcu_wdata     = 8'h00;
      repeat (RESET_CYCLES) @(posedge CLK2);
      #1 rst_n = 1'b1;

      // Idle bus before the first console clock edge
      @(negedge CLK2);
      check_value(32'({rom_we_n, rom_oe_n, rom_bhe_n, rom_ble_n}), 32'hF, "strobes after reset");
      check_value(32'({mcu_req_ready, mcu_rdata_valid}), 32'h0, "MCU handshake after reset");
      @(posedge CLK2);
      #1;

      for (int row = 0; row < NUM_ROWS; row++) begin
         op       = stim_rows[row][COL_OP];
         addr     = snes_addr_t'(stim_rows[row][COL_ADDR]);
         rom_mask = snes_addr_t'(stim_rows[row][COL_MASK]);
         data     = byte_t'(stim_rows[row][COL_DATA]);
         if (op == OP_MCU_RD || op == OP_MCU_WR) begin
            eff = addr;
         end else begin
            eff = addr & rom_mask;
         end
         exp_b = (stim_rows[row][COL_EXP] < 0) ? expected_byte(eff)
                                               : byte_t'(stim_rows[row][COL_EXP]);
         case (op)
            OP_SNES_RD: begin
               run_console_cycle(1'b1, 1'b0, addr, 8'h00);
               check_value(32'(snes_rdata), 32'(exp_b),
                           $sformatf("console read row %0d addr 0x%0h", row, addr));
            end
            OP_SNES_WR, OP_MCU_WR: begin
               update_reference(eff, data);
               if (op == OP_SNES_WR) begin
                  run_console_cycle(1'b0, 1'b1, addr, data);
               end else begin
                  request_mcu(1'b1, addr, data);
               end
               check_value(32'(rom_mem[eff[8:1]]), 32'(ref_mem[eff[8:1]]),
                           $sformatf("ROM word after write row %0d", row));
            end
            default: begin
               count_before = rvalid_count;
               request_mcu(1'b0, addr, 8'h00);
               wait_rdata(count_before);
               check_value(32'(rvalid_count), 32'(count_before + 1),
                           $sformatf("MCU read valid pulses row %0d", row));
               check_value(32'(rvalid_byte), 32'(exp_b),
                           $sformatf("MCU read row %0d addr 0x%0h", row, addr));
            end
         endcase
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== hdl/cart_main.sv ====
module cart_main (
   input  logic                 CLK2,
   input  logic                 rst_n,
   input  logic                 snes_cpu_clk,
   input  cart_pkg::snes_addr_t snes_addr,
   input  logic                 snes_read_n,
   input  logic                 snes_write_n,
   input  cart_pkg::byte_t      snes_wdata,
   input  cart_pkg::snes_addr_t rom_mask,
   input  cart_pkg::word_t      rom_rdata,
   input  logic                 mcu_req_valid,
   input  logic                 mcu_req_write,
   input  cart_pkg::snes_addr_t mcu_addr,
   input  cart_pkg::byte_t      mcu_wdata,
   output cart_pkg::byte_t      snes_rdata,
   output logic                 snes_data_oe,
   output cart_pkg::rom_addr_t  rom_addr,
   output cart_pkg::word_t      rom_wdata,
   output logic                 rom_we_n,
   output logic                 rom_oe_n,
   output logic                 rom_bhe_n,
   output logic                 rom_ble_n,
   output logic                 mcu_req_ready,
   output cart_pkg::byte_t      mcu_rdata,
   output logic                 mcu_rdata_valid
);
   import cart_pkg::*;

   logic  cycle_start;
   slot_t slot;
   logic  phase_mcu;
   logic  mcu_write_go;
   logic  rom_addr0;
   logic  snes_wr_latch;
   logic  snes_rd_latch;
   logic  mcu_rd_latch;

   //////////////////////////////////////////////////////////////////////
   // Schedule and control
   //////////////////////////////////////////////////////////////////////

   slot_timer u_slot_timer (
      .CLK2         (CLK2),
      .rst_n        (rst_n),
      .snes_cpu_clk (snes_cpu_clk),
      .cycle_start  (cycle_start),
      .slot         (slot)
   );

   mem_cycle_fsm u_mem_cycle_fsm (
      .CLK2          (CLK2),
      .rst_n         (rst_n),
      .cycle_start   (cycle_start),
      .slot          (slot),
      .snes_write_n  (snes_write_n),
      .snes_read_n   (snes_read_n),
      .mcu_req_valid (mcu_req_valid),
      .mcu_req_write (mcu_req_write),
      .rom_addr0     (rom_addr0),
      .mcu_req_ready (mcu_req_ready),
      .phase_mcu     (phase_mcu),
      .mcu_write_go  (mcu_write_go),
      .rom_we_n      (rom_we_n),
      .rom_oe_n      (rom_oe_n),
      .rom_bhe_n     (rom_bhe_n),
      .rom_ble_n     (rom_ble_n),
      .snes_data_oe  (snes_data_oe),
      .snes_wr_latch (snes_wr_latch),
      .snes_rd_latch (snes_rd_latch),
      .mcu_rd_latch  (mcu_rd_latch)
   );

   //////////////////////////////////////////////////////////////////////
   // Address and data
   //////////////////////////////////////////////////////////////////////

   rom_addr_mux u_rom_addr_mux (
      .CLK2      (CLK2),
      .rst_n     (rst_n),
      .phase_mcu (phase_mcu),
      .snes_addr (snes_addr),
      .rom_mask  (rom_mask),
      .mcu_addr  (mcu_addr),
      .rom_addr  (rom_addr),
      .rom_addr0 (rom_addr0)
   );

   rom_data_path u_rom_data_path (
      .CLK2            (CLK2),
      .rst_n           (rst_n),
      .snes_wdata      (snes_wdata),
      .mcu_wdata       (mcu_wdata),
      .rom_rdata       (rom_rdata),
      .rom_addr0       (rom_addr0),
      .phase_mcu       (phase_mcu),
      .mcu_write_go    (mcu_write_go),
      .snes_wr_latch   (snes_wr_latch),
      .snes_rd_latch   (snes_rd_latch),
      .mcu_rd_latch    (mcu_rd_latch),
      .rom_wdata       (rom_wdata),
      .snes_rdata      (snes_rdata),
      .mcu_rdata       (mcu_rdata),
      .mcu_rdata_valid (mcu_rdata_valid)
   );

endmodule

// ==== hdl/cart_params.svh ====
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

// Console byte address
`define CART_SNES_AW 24
// ROM word address, console address without bit 0
`define CART_ROM_AW 23

//////////////////////////////////////////////////////////////////////
// Slot schedule
//////////////////////////////////////////////////////////////////////

`define CART_NUM_SLOTS 13
// No cycle running
`define CART_SLOT_IDLE 13
// Slots 12..7 console, 6..0 MCU
`define CART_SLOT_MCU_FIRST 6
`define CART_SLOT_SNES_WR_LATCH 9
`define CART_SLOT_SNES_RD_LATCH 8
`define CART_SLOT_MCU_RD_LATCH 0

// Depth of sampled console clock history
`define CART_CLK_HIST 6

`endif

// ==== hdl/cart_pkg.sv ====
`include "cart_params.svh"

package cart_pkg;

   //////////////////////////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////////////////////////

   // Console side byte address
   typedef logic [`CART_SNES_AW-1:0] snes_addr_t;

   // ROM/PSRAM word address
   typedef logic [`CART_ROM_AW-1:0] rom_addr_t;

   typedef logic [7:0] byte_t;
   typedef logic [15:0] word_t;

   // Slot index, 13 means idle
   typedef logic [3:0] slot_t;

   // Owner of the ROM bus
   typedef enum logic [1:0] {
      BP_IDLE,
      BP_SNES,
      BP_MCU
   } bus_phase_e;

endpackage

// ==== hdl/mem_cycle_fsm.sv ====
`include "cart_params.svh"

module mem_cycle_fsm (
   input  logic            CLK2,
   input  logic            rst_n,
   input  logic            cycle_start,
   input  cart_pkg::slot_t slot,
   input  logic            snes_write_n,
   input  logic            snes_read_n,
   input  logic            mcu_req_valid,
   input  logic            mcu_req_write,
   input  logic            rom_addr0,
   output logic            mcu_req_ready,
   output logic            phase_mcu,
   output logic            mcu_write_go,
   output logic            rom_we_n,
   output logic            rom_oe_n,
   output logic            rom_bhe_n,
   output logic            rom_ble_n,
   output logic            snes_data_oe,
   output logic            snes_wr_latch,
   output logic            snes_rd_latch,
   output logic            mcu_rd_latch
);
   import cart_pkg::*;

   localparam slot_t SLOT_IDLE   = slot_t'(`CART_SLOT_IDLE);
   localparam slot_t SLOT_MCU    = slot_t'(`CART_SLOT_MCU_FIRST);
   localparam slot_t SLOT_SNES_WR = slot_t'(`CART_SLOT_SNES_WR_LATCH);
   localparam slot_t SLOT_SNES_RD = slot_t'(`CART_SLOT_SNES_RD_LATCH);
   localparam slot_t SLOT_MCU_RD  = slot_t'(`CART_SLOT_MCU_RD_LATCH);

   bus_phase_e state;
   logic       snes_is_wr;
   logic       snes_is_rd;
   logic       mcu_act;
   logic       mcu_is_wr;
   logic       we_n_q;
   logic       snes_win;
   logic       mcu_win;
   logic       lane_wr;

   //////////////////////////////////////////////////////////////////////
   // Bus phase state machine
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         state      <= BP_IDLE;
         snes_is_wr <= 1'b0;
         snes_is_rd <= 1'b0;
         mcu_act    <= 1'b0;
         mcu_is_wr  <= 1'b0;
         we_n_q     <= 1'b1;
      end else begin
         we_n_q <= rom_we_n;
         if (cycle_start) begin
            state      <= BP_SNES;
            snes_is_wr <= !snes_write_n;
            snes_is_rd <= !snes_read_n;
            mcu_act    <= 1'b0;
         end else begin
            case (state)
               BP_SNES: begin
                  // Hand the bus to the MCU, taking a waiting request along
                  if (slot == SLOT_MCU) begin
                     state     <= BP_MCU;
                     mcu_act   <= mcu_req_ready;
                     mcu_is_wr <= mcu_req_write;
                  end else if (slot == SLOT_IDLE) begin
                     state <= BP_IDLE;
                  end
               end
               BP_MCU: begin
                  if (slot == '0 || slot == SLOT_IDLE) begin
                     state   <= BP_IDLE;
                     mcu_act <= 1'b0;
                  end
               end
               default: state <= BP_IDLE;
            endcase
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Handshake and strobes
   //////////////////////////////////////////////////////////////////////

   assign mcu_req_ready = (slot == SLOT_MCU) && mcu_req_valid;
   assign mcu_write_go  = mcu_req_ready && mcu_req_write;

   // Address register switches to the MCU one slot ahead of its strobes
   assign phase_mcu = (slot <= SLOT_MCU);

   // Console strobes in slots 12..7, MCU strobes in slots 5..0
   assign snes_win = (state == BP_SNES) && (slot > SLOT_MCU);
   assign mcu_win  = (state == BP_MCU) && mcu_act;

   assign rom_we_n = !((snes_win && snes_is_wr) || (mcu_win && mcu_is_wr));
   assign rom_oe_n = !((snes_win && snes_is_rd && !snes_is_wr) || (mcu_win && !mcu_is_wr));

   // Lanes held one cycle past the WE rise for data hold
   assign lane_wr   = !rom_we_n || !we_n_q;
   assign rom_bhe_n = !(lane_wr && rom_addr0);
   assign rom_ble_n = !(lane_wr && !rom_addr0);

   // Every address maps to ROM
   assign snes_data_oe = !snes_read_n;

   assign snes_wr_latch = snes_win && snes_is_wr && (slot == SLOT_SNES_WR);
   assign snes_rd_latch = snes_win && snes_is_rd && !snes_is_wr && (slot == SLOT_SNES_RD);
   assign mcu_rd_latch  = mcu_win && !mcu_is_wr && (slot == SLOT_MCU_RD);

   a_we_oe_excl: assert property (@(posedge CLK2) disable iff (!rst_n)
      !(!rom_we_n && !rom_oe_n))
      else $error("ROM write and read strobes active together");

   // Every grant opens an MCU phase that serves the request
   a_grant_phase: assert property (@(posedge CLK2) disable iff (!rst_n)
      (mcu_req_ready && !cycle_start) |=> (state == BP_MCU && mcu_act))
      else $error("MCU grant not followed by a served MCU phase");

endmodule

// ==== hdl/rom_addr_mux.sv ====
`include "cart_params.svh"

module rom_addr_mux (
   input  logic                 CLK2,
   input  logic                 rst_n,
   input  logic                 phase_mcu,
   input  cart_pkg::snes_addr_t snes_addr,
   input  cart_pkg::snes_addr_t rom_mask,
   input  cart_pkg::snes_addr_t mcu_addr,
   output cart_pkg::rom_addr_t  rom_addr,
   output logic                 rom_addr0
);
   import cart_pkg::*;

   snes_addr_t snes_masked;
   snes_addr_t addr_q;
   logic       phase_q;

   // Console address wraps inside the ROM image, MCU sees all of it
   assign snes_masked = snes_addr & rom_mask;

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         phase_q <= 1'b0;
      end else begin
         phase_q <= phase_mcu;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Address register
   //////////////////////////////////////////////////////////////////////

   // Console address tracks every cycle outside the MCU phase.
   // MCU address is taken once at phase entry and held, since the
   // MCU may move on after its request is granted
   always_ff @(posedge CLK2) begin
      if (!phase_mcu) begin
         addr_q <= snes_masked;
      end else if (!phase_q) begin
         addr_q <= mcu_addr;
      end
   end

   // Word address above bit 0, bit 0 picks the byte lane
   assign rom_addr  = addr_q[`CART_SNES_AW-1:1];
   assign rom_addr0 = addr_q[0];

endmodule

// ==== hdl/rom_data_path.sv ====
module rom_data_path (
   input  logic            CLK2,
   input  logic            rst_n,
   input  cart_pkg::byte_t snes_wdata,
   input  cart_pkg::byte_t mcu_wdata,
   input  cart_pkg::word_t rom_rdata,
   input  logic            rom_addr0,
   input  logic            phase_mcu,
   input  logic            mcu_write_go,
   input  logic            snes_wr_latch,
   input  logic            snes_rd_latch,
   input  logic            mcu_rd_latch,
   output cart_pkg::word_t rom_wdata,
   output cart_pkg::byte_t snes_rdata,
   output cart_pkg::byte_t mcu_rdata,
   output logic            mcu_rdata_valid
);
   import cart_pkg::*;

   byte_t wr_byte;
   logic  wr_load;
   byte_t rd_byte;

   //////////////////////////////////////////////////////////////////////
   // Write path
   //////////////////////////////////////////////////////////////////////

   // Source follows the bus phase
   assign wr_byte = phase_mcu ? mcu_wdata : snes_wdata;
   assign wr_load = phase_mcu ? mcu_write_go : snes_wr_latch;

   // Same byte on both lanes, BHE/BLE pick the one that is written
   always_ff @(posedge CLK2) begin
      if (wr_load) begin
         rom_wdata <= {wr_byte, wr_byte};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read latches
   //////////////////////////////////////////////////////////////////////

   // High lane for odd addresses
   assign rd_byte = rom_addr0 ? rom_rdata[15:8] : rom_rdata[7:0];

   always_ff @(posedge CLK2) begin
      if (snes_rd_latch) begin
         snes_rdata <= rd_byte;
      end
      if (mcu_rd_latch) begin
         mcu_rdata <= rd_byte;
      end
   end

   // Valid lines up with the freshly latched MCU byte
   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         mcu_rdata_valid <= 1'b0;
      end else begin
         mcu_rdata_valid <= mcu_rd_latch;
      end
   end

endmodule

// ==== hdl/slot_timer.sv ====
`include "cart_params.svh"

module slot_timer (
   input  logic            CLK2,
   input  logic            rst_n,
   input  logic            snes_cpu_clk,
   output logic            cycle_start,
   output cart_pkg::slot_t slot
);
   import cart_pkg::*;

   localparam slot_t SLOT_IDLE  = slot_t'(`CART_SLOT_IDLE);
   localparam slot_t SLOT_FIRST = slot_t'(`CART_NUM_SLOTS - 1);

   // Four low samples followed by two high, oldest sample in the MSB
   localparam logic [`CART_CLK_HIST-1:0] START_PAT = {{(`CART_CLK_HIST-2){1'b0}}, 2'b11};

   logic [1:0]                sync_q;
   logic [`CART_CLK_HIST-1:0] clk_hist;

   //////////////////////////////////////////////////////////////////////
   // Console clock sampling
   //////////////////////////////////////////////////////////////////////

   // Reset to all ones so no start is seen before a real low period
   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         sync_q   <= '1;
         clk_hist <= '1;
      end else begin
         sync_q   <= {sync_q[0], snes_cpu_clk};
         clk_hist <= {clk_hist[`CART_CLK_HIST-2:0], sync_q[1]};
      end
   end

   assign cycle_start = (clk_hist == START_PAT);

   //////////////////////////////////////////////////////////////////////
   // Slot down-counter
   //////////////////////////////////////////////////////////////////////

   // A new start always wins, even in the middle of a schedule
   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         slot <= SLOT_IDLE;
      end else if (cycle_start) begin
         slot <= SLOT_FIRST;
      end else if (slot == '0) begin
         slot <= SLOT_IDLE;
      end else if (slot != SLOT_IDLE) begin
         slot <= slot - 1'b1;
      end
   end

   // Counter stays inside the schedule or parks at idle
   a_slot_range: assert property (@(posedge CLK2) disable iff (!rst_n)
      slot <= SLOT_IDLE)
      else $error("slot index out of range");

endmodule

// ==== run.sh ====
#!/bin/sh
# Verilator build and run, result taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_cart_main -f build.f \
   > build.log 2>&1 \
   && ./obj_dir/Vtb_cart_main > sim.log 2>&1 \
   || echo "Build or simulation exited with an error" >> sim.log

cat build.log sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
